/* regPipeCore.f */
+incdir+.
isaPkg.sv
pipePkg.sv
stageReg.sv
regFieldDecode.sv
controlPipe.sv
addressPath.sv
hazardUnit.sv
regPipeCore.sv
regPipeCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the regPipeCore testbench with Verilator

logFile=sim.log

if ! verilator --binary --timing -Wno-fatal -f regPipeCore.f \
    --top-module regPipeCoreTb -o regPipeCoreSim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/regPipeCoreSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "SIMULATION FAILED" "$logFile"; then
  exit 1
fi

if [ "$simStatus" -ne 0 ]; then
  echo "Simulator exited with status $simStatus"
  exit 1
fi

exit 0

/* regPipeCoreTbTable.svh */
`ifndef REG_PIPE_CORE_TB_TABLE_SVH
`define REG_PIPE_CORE_TB_TABLE_SVH

// One row per cycle with expected values sampled mid-cycle
localparam int numRows = 30;

// Short forms of the forward selects for the table
localparam pipePkg::fwdSelT selN = pipePkg::fwdNone;
localparam pipePkg::fwdSelT selW = pipePkg::fwdFromW;
localparam pipePkg::fwdSelT selM = pipePkg::fwdFromM;

typedef struct packed {
  isaPkg::instrT   instr;
  isaPkg::bankSelT bank;
  logic            busy;
  pipePkg::fwdSelT fwdA;
  pipePkg::fwdSelT fwdB;
  logic            stallD;
  logic            flushE;
  isaPkg::regNumT  wa3W;
} rowT;

rowT rows [numRows];

// Columns are instrD, bankD {rzRsr,rzWa,rzRa2,rzRa1}, memBusy, fwdA, fwdB, stallD, flushE, wa3W
task automatic fillTable();
  // Idle CMP R0,R0 writes nothing
  rows[0]  = '{32'hE1500000, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h00};
  rows[1]  = '{32'hE1500000, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h00};
  rows[2]  = '{32'hE1500000, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h00};
  // ADD R1,R2,R3 then ADD R4,R1,R5 back to back
  rows[3]  = '{32'hE0821003, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h00};
  rows[4]  = '{32'hE0814005, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h00};
  // ADD R2,R7,R8 and ADD R10,R9,R2 one apart
  rows[5]  = '{32'hE0872008, 4'b0000, 1'b0, selM, selN, 1'b0, 1'b0, 5'h00};
  rows[6]  = '{32'hE1500000, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h01};
  rows[7]  = '{32'hE089A002, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h04};
  // Two writers of R3 then ADD R11,R3,R3
  rows[8]  = '{32'hE0873008, 4'b0000, 1'b0, selN, selW, 1'b0, 1'b0, 5'h02};
  rows[9]  = '{32'hE0883007, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h00};
  rows[10] = '{32'hE083B003, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h0A};
  // LDR R4,[R5] then ADD R12,R4,R6 held one cycle
  rows[11] = '{32'hE5954000, 4'b0000, 1'b0, selM, selM, 1'b0, 1'b0, 5'h03};
  rows[12] = '{32'hE084C006, 4'b0000, 1'b0, selN, selN, 1'b1, 1'b1, 5'h03};
  rows[13] = '{32'hE084C006, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h0B};
  // UMULL R8,R9,R2,R3 then ADD R13,R8,R1 reads RdLo
  rows[14] = '{32'hE0898392, 4'b0000, 1'b0, selW, selN, 1'b0, 1'b0, 5'h04};
  rows[15] = '{32'hE088D001, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h00};
  // MUL R6,R2,R3 then ADD R14,R9,R6 with RdHi R9 never tracked
  rows[16] = '{32'hE0060392, 4'b0000, 1'b0, selM, selN, 1'b0, 1'b0, 5'h0C};
  rows[17] = '{32'hE089E006, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h08};
  // Banked R7 write missed by an unbanked reader and hit by a banked one
  rows[18] = '{32'hE0827003, 4'b0100, 1'b0, selN, selM, 1'b0, 1'b0, 5'h0D};
  rows[19] = '{32'hE0875007, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h06};
  rows[20] = '{32'hE0876001, 4'b0001, 1'b0, selN, selN, 1'b0, 1'b0, 5'h0E};
  // LDR R9,[R1] then ADD R10,R9,R3 under busy memory
  rows[21] = '{32'hE5919000, 4'b0000, 1'b0, selW, selN, 1'b0, 1'b0, 5'h17};
  rows[22] = '{32'hE089A003, 4'b0000, 1'b1, selN, selN, 1'b1, 1'b0, 5'h05};
  rows[23] = '{32'hE089A003, 4'b0000, 1'b1, selN, selN, 1'b1, 1'b0, 5'h05};
  rows[24] = '{32'hE089A003, 4'b0000, 1'b1, selN, selN, 1'b1, 1'b0, 5'h05};
  // Memory free again so the load-use bubble follows
  rows[25] = '{32'hE089A003, 4'b0000, 1'b0, selN, selN, 1'b1, 1'b1, 5'h05};
  rows[26] = '{32'hE089A003, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h06};
  // Drain
  rows[27] = '{32'hE1500000, 4'b0000, 1'b0, selW, selN, 1'b0, 1'b0, 5'h09};
  rows[28] = '{32'hE1500000, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h00};
  rows[29] = '{32'hE1500000, 4'b0000, 1'b0, selN, selN, 1'b0, 1'b0, 5'h0A};
endtask

`endif

/* regPipeCoreTb.sv */
`timescale 1ns/1ps

module regPipeCoreTb;

  localparam int clkPeriod = 20;
  localparam int resetCycles = 10;
  localparam int driveDelay = 2;

  // CMP R0,R0, reads only
  localparam isaPkg::instrT nopInstr = 32'hE1500000;

  logic            clk;
  logic            arstN;
  isaPkg::instrT   instrD;
  isaPkg::bankSelT bankD;
  logic            memBusy;
  pipePkg::hazardT hazard;
  isaPkg::regNumT  wa3W;

  // Row under test, shown in error lines
  int rowIdx;

  `include "regPipeCoreTbTable.svh"

  regPipeCore #(.regNumWidth(5)) dut_i (
    .clk(clk),
    .arstN(arstN),
    .instrD(instrD),
    .bankD(bankD),
    .memBusy(memBusy),
    .hazard(hazard),
    .wa3W(wa3W)
  );

  // ====================
  // Clock and watchdog
  // ====================
  always #(clkPeriod / 2) clk = ~clk;

  // Twice the length of reset plus table
  initial begin
    #((numRows + resetCycles) * clkPeriod * 2);
    abortRun("Watchdog expired, the table did not finish");
  end

  // ====================
  // Compare tasks
  // ====================
  task automatic abortRun(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at row %0d", rowIdx);
  endtask

  task automatic checkFwd(input string name, input pipePkg::fwdSelT expVal,
                          input pipePkg::fwdSelT actVal);
    if (actVal !== expVal) begin
      $display("Fail at %0d ns, row %0d: %s expected %s, got %s",
               $time, rowIdx, name, expVal.name(), actVal.name());
      abortRun("Forward select mismatch");
    end
  endtask

  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      $display("Fail at %0d ns, row %0d: %s expected %b, got %b",
               $time, rowIdx, name, expVal, actVal);
      abortRun("Control bit mismatch");
    end
  endtask

  task automatic checkReg(input string name, input isaPkg::regNumT expVal,
                          input isaPkg::regNumT actVal);
    if (actVal !== expVal) begin
      $display("Fail at %0d ns, row %0d: %s expected 0x%h, got 0x%h",
               $time, rowIdx, name, expVal, actVal);
      abortRun("Register number mismatch");
    end
  endtask

  // ====================
  // Table loop
  // ====================
  initial begin
    logic holdD;
    clk = 1'b0;
    arstN = 1'b0;
    instrD = nopInstr;
    bankD = '0;
    memBusy = 1'b0;
    rowIdx = 0;
    holdD = 1'b0;
    fillTable();

    repeat (resetCycles) @(posedge clk);
    #driveDelay;
    arstN = 1'b1;

    for (int i = 0; i < numRows; i++) begin
      @(posedge clk);
      #driveDelay;
      rowIdx = i;
      // Fetch keeps a stalled instruction and its banks in Decode
      if (!holdD) begin
        instrD = rows[i].instr;
        bankD = rows[i].bank;
      end
      memBusy = rows[i].busy;

      // Mid-cycle, well clear of both edges
      @(negedge clk);
      checkFwd("fwdA", rows[i].fwdA, hazard.fwdA);
      checkFwd("fwdB", rows[i].fwdB, hazard.fwdB);
      checkBit("stallD", rows[i].stallD, hazard.stallD);
      checkBit("stallF", rows[i].stallD, hazard.stallF);
      checkBit("flushE", rows[i].flushE, hazard.flushE);
      // Back end freezes only for busy memory
      checkBit("stallE", rows[i].busy, hazard.stallE);
      checkBit("stallM", rows[i].busy, hazard.stallM);
      checkBit("stallW", rows[i].busy, hazard.stallW);
      checkReg("wa3W", rows[i].wa3W, wa3W);
      holdD = rows[i].stallD;
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* regPipeCore.sv */
`timescale 1ns/1ps

// Register-number tracking and hazard detection, top level
module regPipeCore #(
  parameter int regNumWidth = 5
) (
  input  logic            clk,
  input  logic            arstN,
  input  isaPkg::instrT   instrD,
  input  isaPkg::bankSelT bankD,
  input  logic            memBusy,
  output pipePkg::hazardT hazard,
  output isaPkg::regNumT  wa3W
);

  isaPkg::decodeT     decodeD;
  isaPkg::instrT      instrE;
  pipePkg::stageCtrlT ctrlE;
  pipePkg::stageCtrlT ctrlM;
  pipePkg::stageCtrlT ctrlW;
  pipePkg::matchT     match;

  // ====================
  // Decode
  // ====================
  regFieldDecode decode_i (
    .instrD(instrD),
    .decodeD(decodeD)
  );

  // ====================
  // Pipelined state
  // ====================
  // Write controls per stage
  controlPipe ctrl_i (
    .clk(clk), .arstN(arstN),
    .decodeD(decodeD), .instrD(instrD), .hazard(hazard),
    .ctrlE(ctrlE), .ctrlM(ctrlM), .ctrlW(ctrlW), .instrE(instrE)
  );

  // Register numbers and compares
  addressPath #(.regNumWidth(regNumWidth)) addr_i (
    .clk(clk), .arstN(arstN),
    .instrD(instrD), .instrE(instrE), .decodeD(decodeD), .bankD(bankD),
    .ctrlE(ctrlE), .hazard(hazard),
    .match(match), .wa3W(wa3W)
  );

  // ====================
  // Hazard policy
  // ====================
  // Feeds stall and flush back into both pipes
  hazardUnit hazard_i (
    .match(match),
    .ctrlE(ctrlE),
    .ctrlM(ctrlM),
    .ctrlW(ctrlW),
    .memBusy(memBusy),
    .hazard(hazard)
  );

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ps

// Hazard policy
// Purely combinational, same-cycle outputs from pipeline state
module hazardUnit (
  input  pipePkg::matchT     match,
  input  pipePkg::stageCtrlT ctrlE,
  input  pipePkg::stageCtrlT ctrlM,
  input  pipePkg::stageCtrlT ctrlW,
  input  logic               memBusy,
  output pipePkg::hazardT    hazard
);

  logic ldrStall;

  // M has the newer value so it wins over W
  function automatic pipePkg::fwdSelT pickFwd(
    input logic hitM,
    input logic hitW,
    input logic wrM,
    input logic wrW
  );
    pipePkg::fwdSelT sel;
    if (hitM && wrM) begin
      sel = pipePkg::fwdFromM;
    end else if (hitW && wrW) begin
      sel = pipePkg::fwdFromW;
    end else begin
      sel = pipePkg::fwdNone;
    end
    return sel;
  endfunction

  // ====================
  // Forwarding
  // ====================
  always_comb begin
    hazard.fwdA = pickFwd(match.m1EM, match.m1EW, ctrlM.regWrite, ctrlW.regWrite);
    hazard.fwdB = pickFwd(match.m2EM, match.m2EW, ctrlM.regWrite, ctrlW.regWrite);
  end

  // ====================
  // Stalls and bubble
  // ====================

  // Load in E, reader in D, data not ready until W
  assign ldrStall = (match.m1DE || match.m2DE) && ctrlE.memToReg;

  always_comb begin
    // Front end holds for a load-use or a busy memory
    hazard.stallF = ldrStall || memBusy;
    hazard.stallD = ldrStall || memBusy;

    // Busy memory freezes the back end as well
    hazard.stallE = memBusy;
    hazard.stallM = memBusy;
    hazard.stallW = memBusy;

    // No bubble while E is frozen, it would be lost anyway
    hazard.flushE = ldrStall && !memBusy;
  end

endmodule

/* addressPath.sv */
`timescale 1ns/1ps

// Register-number path, selection in D, pipelining and equality compares
module addressPath #(
  parameter int regNumWidth = 5
) (
  input  logic               clk,
  input  logic               arstN,
  input  isaPkg::instrT      instrD,
  input  isaPkg::instrT      instrE,
  input  isaPkg::decodeT     decodeD,
  input  isaPkg::bankSelT    bankD,
  input  pipePkg::stageCtrlT ctrlE,
  input  pipePkg::hazardT    hazard,
  output pipePkg::matchT     match,
  output isaPkg::regNumT     wa3W
);

  typedef logic [regNumWidth-1:0] addrT;

  isaPkg::regIdxT rnD;
  isaPkg::regIdxT rdD;
  isaPkg::regIdxT rsD;
  isaPkg::regIdxT rmD;
  isaPkg::regIdxT ra1IdxD;
  isaPkg::regIdxT ra2IdxD;
  isaPkg::regIdxT destIdxD;
  addrT           ra1D, ra2D, wa3D;
  addrT           ra1E, ra2E, wa3RawE, rdLoE, wa3E;
  addrT           wa3M, wa3WInt;

  // Bank bit dropped when regNumWidth is 4
  function automatic addrT mkAddr(input logic bank, input isaPkg::regIdxT idx);
    isaPkg::regNumT full;
    full = {bank, idx};
    return addrT'(full);
  endfunction

  // ====================
  // Decode
  // ====================
  assign rnD = instrD[isaPkg::rnLsb +: 4];
  assign rdD = instrD[isaPkg::rdLsb +: 4];
  assign rsD = instrD[isaPkg::rsLsb +: 4];
  assign rmD = instrD[isaPkg::rmLsb +: 4];

  // Multiply reads Rm, then RSR shift amount, then PC for branches
  assign ra1IdxD = decodeD.multSelect ? rmD :
                   bankD.rzRsr        ? rsD :
                   decodeD.regSrc[0]  ? isaPkg::pcIndex : rnD;
  assign ra2IdxD = decodeD.multSelect ? rsD :
                   decodeD.regSrc[1]  ? rdD : rmD;
  // Multiply destination sits in the Rn field
  assign destIdxD = decodeD.multSelect ? rnD : rdD;

  assign ra1D = mkAddr(bankD.rzRa1, ra1IdxD);
  assign ra2D = mkAddr(bankD.rzRa2, ra2IdxD);
  assign wa3D = mkAddr(bankD.rzWa, destIdxD);

  // ====================
  // Execute
  // ====================
  stageReg #(.payloadT(addrT)) ra1RegE_i (.clk(clk), .arstN(arstN), .en(~hazard.stallE),
    .clr(hazard.flushE), .d(ra1D), .q(ra1E));
  stageReg #(.payloadT(addrT)) ra2RegE_i (.clk(clk), .arstN(arstN), .en(~hazard.stallE),
    .clr(hazard.flushE), .d(ra2D), .q(ra2E));
  stageReg #(.payloadT(addrT)) wa3RegE_i (.clk(clk), .arstN(arstN), .en(~hazard.stallE),
    .clr(hazard.flushE), .d(wa3D), .q(wa3RawE));

  // Long multiply RdLo, always unbanked
  assign rdLoE = mkAddr(1'b0, instrE[isaPkg::rdLsb +: 4]);
  assign wa3E = ctrlE.writeMultLo ? rdLoE : wa3RawE;

  // ====================
  // Memory and Writeback
  // ====================
  stageReg #(.payloadT(addrT)) wa3RegM_i (.clk(clk), .arstN(arstN), .en(~hazard.stallM),
    .clr(1'b0), .d(wa3E), .q(wa3M));
  stageReg #(.payloadT(addrT)) wa3RegW_i (.clk(clk), .arstN(arstN), .en(~hazard.stallW),
    .clr(1'b0), .d(wa3M), .q(wa3WInt));

  assign wa3W = isaPkg::regNumT'(wa3WInt);

  // Compares only, policy lives in hazardUnit
  always_comb begin
    match.m1EM = (ra1E == wa3M);
    match.m1EW = (ra1E == wa3WInt);
    match.m2EM = (ra2E == wa3M);
    match.m2EW = (ra2E == wa3WInt);
    match.m1DE = (ra1D == wa3E);
    match.m2DE = (ra2D == wa3E);
  end

endmodule

/* controlPipe.sv */
`timescale 1ns/1ps

// Write controls and instruction word, Decode to Writeback
module controlPipe (
  input  logic               clk,
  input  logic               arstN,
  input  isaPkg::decodeT     decodeD,
  input  isaPkg::instrT      instrD,
  input  pipePkg::hazardT    hazard,
  output pipePkg::stageCtrlT ctrlE,
  output pipePkg::stageCtrlT ctrlM,
  output pipePkg::stageCtrlT ctrlW,
  output isaPkg::instrT      instrE
);

  pipePkg::stageCtrlT ctrlD;

  // Keep only the write-related bits
  assign ctrlD.regWrite = decodeD.regWrite;
  assign ctrlD.memToReg = decodeD.memToReg;
  assign ctrlD.writeMultLo = decodeD.writeMultLo;

  // ====================
  // Execute
  // ====================
  // Bubble clears regWrite and memToReg so nothing forwards from it
  stageReg #(.payloadT(pipePkg::stageCtrlT)) ctrlRegE_i (
    .clk(clk), .arstN(arstN), .en(~hazard.stallE), .clr(hazard.flushE),
    .d(ctrlD), .q(ctrlE)
  );

  // Instruction needed in E for the RdLo field
  stageReg #(.payloadT(isaPkg::instrT)) instrRegE_i (
    .clk(clk), .arstN(arstN), .en(~hazard.stallE), .clr(hazard.flushE),
    .d(instrD), .q(instrE)
  );

  // ====================
  // Memory and Writeback
  // ====================
  stageReg #(.payloadT(pipePkg::stageCtrlT)) ctrlRegM_i (
    .clk(clk), .arstN(arstN), .en(~hazard.stallM), .clr(1'b0),
    .d(ctrlE), .q(ctrlM)
  );

  stageReg #(.payloadT(pipePkg::stageCtrlT)) ctrlRegW_i (
    .clk(clk), .arstN(arstN), .en(~hazard.stallW), .clr(1'b0),
    .d(ctrlM), .q(ctrlW)
  );

endmodule

/* regFieldDecode.sv */
`timescale 1ns/1ps

// Decode-stage field decoder
// Produces register selects and write controls only, no ALU controls
module regFieldDecode (
  input  isaPkg::instrT  instrD,
  output isaPkg::decodeT decodeD
);

  logic [1:0] op;
  logic [3:0] cmd;
  logic       isLoad;
  logic       mulNibOk;
  logic       isShortMul;
  logic       isLongMul;

  // Raw fields
  assign op = instrD[isaPkg::opLsb +: 2];
  assign cmd = instrD[isaPkg::cmdLsb +: 4];
  assign isLoad = instrD[isaPkg::loadBit];

  // ====================
  // Multiply class
  // ====================
  assign mulNibOk = (instrD[isaPkg::mulNibLsb +: 4] == isaPkg::mulNib);

  // MUL / MLA
  assign isShortMul = mulNibOk && (instrD[27:22] == 6'd0);

  // UMULL, UMLAL, SMULL, SMLAL
  assign isLongMul = mulNibOk && (instrD[27:24] == 4'd0) && instrD[isaPkg::longBit];

  // ====================
  // Controls per class
  // ====================
  always_comb begin
    decodeD = '0;
    if (isShortMul || isLongMul) begin
      decodeD.multSelect = 1'b1;
      decodeD.regWrite = 1'b1;
      // Long form also writes RdLo from Execute
      decodeD.writeMultLo = isLongMul;
    end else begin
      case (op)
        2'b00: begin
          // TST, TEQ, CMP, CMN only touch flags
          decodeD.regWrite = (cmd[3:2] != 2'b10);
        end
        2'b01: begin
          decodeD.regWrite = isLoad;
          decodeD.memToReg = isLoad;
          // Store data comes from Rd
          decodeD.regSrc[1] = ~isLoad;
        end
        2'b10: begin
          // Branch target is PC relative
          decodeD.regSrc[0] = 1'b1;
        end
        default: begin
          decodeD.regWrite = 1'b0;
        end
      endcase
    end
  end

endmodule

/* stageReg.sv */
`timescale 1ns/1ps

// Generic pipeline register
// Payload type set per instance (addresses, controls, instruction)
module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    en,
  input  logic    clr,
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      q <= '0;
    end else if (en) begin
      // Bubble only when the stage actually advances
      if (clr) begin
        q <= '0;
      end else begin
        q <= d;
      end
    end
  end

endmodule

/* pipePkg.sv */
package pipePkg;

  // ====================
  // Address compare results
  // ====================

  // E operand vs M/W destination, and D operand vs E destination
  typedef struct packed {
    logic m1EM;
    logic m1EW;
    logic m2EM;
    logic m2EW;
    logic m1DE;
    logic m2DE;
  } matchT;

  // ====================
  // Per-stage write controls
  // ====================

  // Only the bits the hazard logic has to see
  typedef struct packed {
    logic regWrite;
    logic memToReg;
    logic writeMultLo;
  } stageCtrlT;

  // ====================
  // Hazard outputs
  // ====================

  // Operand source in Execute
  typedef enum logic [1:0] {
    fwdNone  = 2'b00,
    fwdFromW = 2'b01,
    fwdFromM = 2'b10
  } fwdSelT;

  typedef struct packed {
    logic   stallF;
    logic   stallD;
    logic   stallE;
    logic   stallM;
    logic   stallW;
    logic   flushE;
    fwdSelT fwdA;
    fwdSelT fwdB;
  } hazardT;

endpackage

/* isaPkg.sv */
package isaPkg;

  // ====================
  // Instruction word and register numbers
  // ====================

  // Raw 32-bit ARM-style instruction
  typedef logic [31:0] instrT;

  // Plain 4-bit register index, R0..R15
  typedef logic [3:0] regIdxT;

  // Bank bit on top of the 4-bit index
  typedef logic [4:0] regNumT;

  // Program counter index, read as Rn by branches
  localparam regIdxT pcIndex = 4'd15;

  // ====================
  // Field positions
  // ====================

  // Register fields, each 4 bits wide
  localparam int rnLsb = 16;
  localparam int rdLsb = 12;
  localparam int rsLsb = 8;
  localparam int rmLsb = 0;

  // Major class in 27:26, data-processing opcode in 24:21
  localparam int opLsb = 26;
  localparam int cmdLsb = 21;

  // Load/store direction, set for a load
  localparam int loadBit = 20;

  // Multiply class markers
  localparam int longBit = 23;
  localparam int mulNibLsb = 4;
  localparam logic [3:0] mulNib = 4'b1001;

  // ====================
  // Decode results
  // ====================

  // Bank bits from the outer controller, rzRa1 in bit 0
  typedef struct packed {
    logic rzRsr;
    logic rzWa;
    logic rzRa2;
    logic rzRa1;
  } bankSelT;

  // regSrc[0] picks PC as Rn, regSrc[1] picks Rd as second read
  typedef struct packed {
    logic       multSelect;
    logic [1:0] regSrc;
    logic       regWrite;
    logic       memToReg;
    logic       writeMultLo;
  } decodeT;

endpackage
